// File: hdl/fetch_pkg.sv
package fetch_pkg;

    // datapath widths
    localparam int xlen = 32;
    localparam int line_bits = 64;

    // bytes per instruction word and per cache line
    localparam int word_bytes = xlen / 8;
    localparam int line_bytes = line_bits / 8;

    // byte offset inside a line, 3 bits for 64-bit lines
    localparam int offset_bits = $clog2(line_bytes);

    // first fetch address after reset
    localparam logic [xlen-1:0] reset_pc = 32'h0000_1000;

    // memory image pattern, word at byte address a holds a ^ inst_pattern
    localparam logic [xlen-1:0] inst_pattern = 32'h5a3c_0f13;

    // icache fill sequencing
    typedef enum logic {
        idle,
        wait_fill
    } cache_state_e;

endpackage

// File: hdl/icache.sv
module icache import fetch_pkg::*; #(
    parameter int cache_lines = 16
) (
    input  logic                 clock,
    input  logic                 reset,

    // lookup port from the prefetch queue
    input  logic [xlen-1:0]      fetch_addr,
    output logic                 hit,
    output logic [line_bits-1:0] line,

    // line fill port to external memory
    output logic                 mem_req,
    output logic [xlen-1:0]      mem_addr,
    input  logic                 mem_valid,
    input  logic [line_bits-1:0] mem_line
);

    localparam int index_bits = $clog2(cache_lines);
    localparam int tag_bits = xlen - offset_bits - index_bits;
    localparam int line_addr_bits = xlen - offset_bits;

    // per-line storage
    logic [cache_lines-1:0] line_valid;
    logic [tag_bits-1:0]    tag_mem [cache_lines];
    logic [line_bits-1:0]   data_mem [cache_lines];

    // lookup fields
    logic [index_bits-1:0] lookup_index;
    logic [tag_bits-1:0]   lookup_tag;

    // outstanding fill
    logic [line_addr_bits-1:0] fill_line_addr;
    logic [index_bits-1:0]     fill_index;
    logic [tag_bits-1:0]       fill_tag;

    cache_state_e state;
    cache_state_e state_next;
    logic         start_fill;
    logic         fill_done;

    // address split: tag | index | byte offset
    assign lookup_index = fetch_addr[offset_bits +: index_bits];
    assign lookup_tag   = fetch_addr[xlen-1 -: tag_bits];

    // combinational lookup, answered in the same cycle
    assign hit  = line_valid[lookup_index] && (tag_mem[lookup_index] == lookup_tag);
    assign line = data_mem[lookup_index];

    // the returned line goes where its own address points,
    // not where the queue is looking now
    assign fill_index = fill_line_addr[index_bits-1:0];
    assign fill_tag   = fill_line_addr[line_addr_bits-1 -: tag_bits];

    // request address is always line aligned
    assign mem_addr = {fill_line_addr, {offset_bits{1'b0}}};

    // one fill at a time
    always_comb begin
        state_next = state;
        start_fill = 1'b0;
        fill_done  = 1'b0;
        case (state)
            idle: begin
                if (!hit) begin
                    start_fill = 1'b1;
                    state_next = wait_fill;
                end
            end
            wait_fill: begin
                // latency is unknown, wait for the response strobe
                if (mem_valid) begin
                    fill_done  = 1'b1;
                    state_next = idle;
                end
            end
            default: begin
                state_next = idle;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state   <= idle;
            mem_req <= 1'b0;
        end else begin
            state <= state_next;
            // single cycle pulse, one cycle after the miss
            mem_req <= start_fill;
        end
    end

    // capture the missing line address with the request
    always_ff @(posedge clock) begin
        if (start_fill) begin
            fill_line_addr <= fetch_addr[xlen-1:offset_bits];
        end
    end

    // valid bits
    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= '0;
        end else if (fill_done) begin
            line_valid[fill_index] <= 1'b1;
        end
    end

    // tag and data arrays, written on the response cycle
    always_ff @(posedge clock) begin
        if (fill_done) begin
            tag_mem[fill_index]  <= fill_tag;
            data_mem[fill_index] <= mem_line;
        end
    end

endmodule

// File: hdl/prefetch_queue.sv
module prefetch_queue import fetch_pkg::*; #(
    parameter int queue_depth = 8
) (
    input  logic                 clock,
    input  logic                 reset,

    // decoder side
    input  logic                 take,
    input  logic                 take_branch,
    input  logic [xlen-1:0]      branch_target,
    output logic                 valid,
    output logic [xlen-1:0]      inst,
    output logic [xlen-1:0]      pc,
    output logic [xlen-1:0]      npc,

    // icache side
    output logic [xlen-1:0]      fetch_addr,
    input  logic                 hit,
    input  logic [line_bits-1:0] line
);

    localparam int ptr_bits = (queue_depth > 1) ? $clog2(queue_depth) : 1;
    localparam int count_bits = $clog2(queue_depth + 1);

    // entry storage, instruction and its pc
    logic [xlen-1:0] inst_mem [queue_depth];
    logic [xlen-1:0] pc_mem [queue_depth];

    logic [ptr_bits-1:0]   head;
    logic [ptr_bits-1:0]   tail;
    logic [count_bits-1:0] count;
    logic [xlen-1:0]       fetch_pc;

    logic [xlen-1:0] fetch_word;
    logic            pop;
    logic            push;
    logic            room;

    // circular increment, depth need not be a power of two
    function automatic logic [ptr_bits-1:0] next_ptr(input logic [ptr_bits-1:0] ptr);
        if (ptr == ptr_bits'(queue_depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // cache is addressed by line
    assign fetch_addr = {fetch_pc[xlen-1:offset_bits], {offset_bits{1'b0}}};

    // upper word when pc bit 2 is set
    assign fetch_word = fetch_pc[offset_bits-1] ? line[line_bits-1 -: xlen] : line[xlen-1:0];

    // a branch discards the head, so it is not counted as accepted
    assign pop = valid && take && !take_branch;

    // a slot freed by this cycle's pop may be refilled at once
    assign room = (count < count_bits'(queue_depth)) || pop;
    assign push = hit && room && !take_branch;

    // pointers, occupancy and fetch pc
    always_ff @(posedge clock) begin
        if (reset) begin
            head     <= '0;
            tail     <= '0;
            count    <= '0;
            fetch_pc <= reset_pc;
        end else if (take_branch) begin
            // flush and redirect
            head     <= '0;
            tail     <= '0;
            count    <= '0;
            fetch_pc <= branch_target;
        end else begin
            if (pop) begin
                head <= next_ptr(head);
            end
            if (push) begin
                tail     <= next_ptr(tail);
                fetch_pc <= fetch_pc + xlen'(word_bytes);
            end
            count <= count + count_bits'(push) - count_bits'(pop);
        end
    end

    // entry write, pc stored alongside so the decoder sees it
    always_ff @(posedge clock) begin
        if (push) begin
            inst_mem[tail] <= fetch_word;
            pc_mem[tail]   <= fetch_pc;
        end
    end

    // head entry to decoder
    assign valid = (count != '0);
    assign inst  = inst_mem[head];
    assign pc    = pc_mem[head];
    assign npc   = pc_mem[head] + xlen'(word_bytes);

endmodule

// File: hdl/fetch_top.sv
module fetch_top import fetch_pkg::*; #(
    parameter int queue_depth = 8,
    parameter int cache_lines = 16
) (
    input  logic                 clock,
    input  logic                 reset,

    // decoder interface
    input  logic                 take,
    input  logic                 take_branch,
    input  logic [xlen-1:0]      branch_target,
    output logic                 valid,
    output logic [xlen-1:0]      inst,
    output logic [xlen-1:0]      pc,
    output logic [xlen-1:0]      npc,

    // memory line port
    output logic                 mem_req,
    output logic [xlen-1:0]      mem_addr,
    input  logic                 mem_valid,
    input  logic [line_bits-1:0] mem_line
);

    // queue to cache lookup
    logic [xlen-1:0]      fetch_addr;
    logic                 hit;
    logic [line_bits-1:0] line;

    prefetch_queue #(
        .queue_depth   (queue_depth)
    ) i_prefetch_queue (
        .clock         (clock),
        .reset         (reset),
        .take          (take),
        .take_branch   (take_branch),
        .branch_target (branch_target),
        .valid         (valid),
        .inst          (inst),
        .pc            (pc),
        .npc           (npc),
        .fetch_addr    (fetch_addr),
        .hit           (hit),
        .line          (line)
    );

    icache #(
        .cache_lines   (cache_lines)
    ) i_icache (
        .clock         (clock),
        .reset         (reset),
        .fetch_addr    (fetch_addr),
        .hit           (hit),
        .line          (line),
        .mem_req       (mem_req),
        .mem_addr      (mem_addr),
        .mem_valid     (mem_valid),
        .mem_line      (mem_line)
    );

endmodule

// File: tests/tb_clock.sv
module tb_clock #(
    parameter int period = 20
) (
    output logic clock
);

    initial begin
        clock = 1'b0;
    end

    // free running, first rising edge at half a period
    always #(period / 2) clock = ~clock;

endmodule

// File: tests/tb_memory.sv
module tb_memory import fetch_pkg::*; #(
    parameter int max_latency = 6
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 mem_req,
    input  logic [xlen-1:0]      mem_addr,
    output logic                 mem_valid,
    output logic [line_bits-1:0] mem_line
);

    // image word at byte address a is a ^ inst_pattern
    function automatic logic [xlen-1:0] image_word(input logic [xlen-1:0] addr);
        return addr ^ inst_pattern;
    endfunction

    initial begin
        int              latency;
        logic [xlen-1:0] line_addr;
        mem_valid = 1'b0;
        mem_line  = '0;
        forever begin
            @(posedge clock);
            #2;
            if (!reset && mem_req) begin
                latency   = $urandom_range(1, max_latency);
                line_addr = mem_addr;
                repeat (latency) @(posedge clock);
                #2;
                // upper half is the word at line_addr + 4
                mem_valid = 1'b1;
                mem_line  = {image_word(line_addr + 32'd4), image_word(line_addr)};
                @(posedge clock);
                #2;
                mem_valid = 1'b0;
                mem_line  = '0;
            end
        end
    end

endmodule

// File: tests/fetch_checker.sv
module fetch_checker import fetch_pkg::*; (
    input logic            clock,
    input logic            reset,
    input logic            take,
    input logic            take_branch,
    input logic [xlen-1:0] branch_target,
    input logic            valid,
    input logic [xlen-1:0] inst,
    input logic [xlen-1:0] pc,
    input logic [xlen-1:0] npc,
    input logic            mem_req,
    input logic [xlen-1:0] mem_addr,
    input logic            mem_valid
);

    int              fail_count = 0;
    logic [xlen-1:0] expected_pc;
    logic            outstanding;

    // next pc the decoder should accept
    always_ff @(posedge clock) begin
        if (reset) begin
            expected_pc <= reset_pc;
        end else if (take_branch) begin
            expected_pc <= branch_target;
        end else if (valid && take) begin
            expected_pc <= expected_pc + 32'd4;
        end
    end

    // line request in flight
    always_ff @(posedge clock) begin
        if (reset) begin
            outstanding <= 1'b0;
        end else if (mem_req) begin
            outstanding <= 1'b1;
        end else if (mem_valid) begin
            outstanding <= 1'b0;
        end
    end

    content_check: assert property (@(posedge clock) disable iff (reset)
        valid |-> inst == (pc ^ inst_pattern))
    else begin
        $error("FAILED content expected %h actual %h",
               $sampled(pc) ^ inst_pattern, $sampled(inst));
        fail_count++;
    end

    npc_check: assert property (@(posedge clock) disable iff (reset)
        valid |-> npc == pc + 32'd4)
    else begin
        $error("FAILED npc expected %h actual %h", $sampled(pc) + 32'd4, $sampled(npc));
        fail_count++;
    end

    order_check: assert property (@(posedge clock) disable iff (reset)
        (valid && take && !take_branch) |-> pc == expected_pc)
    else begin
        $error("FAILED order expected %h actual %h", $sampled(expected_pc), $sampled(pc));
        fail_count++;
    end

    flush_check: assert property (@(posedge clock) disable iff (reset)
        take_branch |=> !valid)
    else begin
        $error("FAILED flush expected valid 0 actual %b", $sampled(valid));
        fail_count++;
    end

    single_request_check: assert property (@(posedge clock) disable iff (reset)
        mem_req |-> !outstanding)
    else begin
        $error("FAILED single_request expected outstanding 0 actual %b",
               $sampled(outstanding));
        fail_count++;
    end

    align_check: assert property (@(posedge clock) disable iff (reset)
        mem_req |-> mem_addr[2:0] == 3'b000)
    else begin
        $error("FAILED align expected 0 actual %h", $sampled(mem_addr[2:0]));
        fail_count++;
    end

    reset_check: assert property (@(posedge clock)
        reset |=> (!valid && !mem_req))
    else begin
        $error("FAILED reset expected valid 0 mem_req 0 actual valid %b mem_req %b",
               $sampled(valid), $sampled(mem_req));
        fail_count++;
    end

endmodule

bind fetch_top fetch_checker i_checker (
    .clock         (clock),
    .reset         (reset),
    .take          (take),
    .take_branch   (take_branch),
    .branch_target (branch_target),
    .valid         (valid),
    .inst          (inst),
    .pc            (pc),
    .npc           (npc),
    .mem_req       (mem_req),
    .mem_addr      (mem_addr),
    .mem_valid     (mem_valid)
);

// File: tests/tb_fetch.sv
module tb_fetch import fetch_pkg::*; ();

    localparam int clock_period = 20;
    localparam int reset_cycles = 10;
    localparam int max_latency = 6;
    localparam int instr_total = 300;
    localparam int watchdog_time = instr_total * (max_latency + 4) * clock_period * 2;

    logic                 clock;
    logic                 reset;
    logic                 take;
    logic                 take_branch;
    logic [xlen-1:0]      branch_target;
    logic                 valid;
    logic [xlen-1:0]      inst;
    logic [xlen-1:0]      pc;
    logic [xlen-1:0]      npc;
    logic                 mem_req;
    logic [xlen-1:0]      mem_addr;
    logic                 mem_valid;
    logic [line_bits-1:0] mem_line;
    int                   accepted;
    logic [xlen-1:0]      last_pc;

    tb_clock #(.period(clock_period)) i_clock (.clock(clock));

    tb_memory #(.max_latency(max_latency)) i_memory (
        .clock(clock), .reset(reset), .mem_req(mem_req), .mem_addr(mem_addr),
        .mem_valid(mem_valid), .mem_line(mem_line)
    );

    fetch_top #(.queue_depth(8), .cache_lines(16)) i_dut (
        .clock(clock), .reset(reset), .take(take), .take_branch(take_branch),
        .branch_target(branch_target), .valid(valid), .inst(inst), .pc(pc), .npc(npc),
        .mem_req(mem_req), .mem_addr(mem_addr), .mem_valid(mem_valid), .mem_line(mem_line)
    );

    // one cycle of decoder inputs, counting accepted entries
    task automatic drive_cycle(input logic take_in, input logic branch_in,
                               input logic [xlen-1:0] target_in);
        take          = take_in;
        take_branch   = branch_in;
        branch_target = target_in;
        if (valid && take_in && !branch_in) begin
            accepted++;
            last_pc = pc;
        end
        @(posedge clock);
        #2;
    endtask

    task automatic run_accepts(input int n, input bit random_take);
        int   goal;
        logic take_now;
        goal = accepted + n;
        while (accepted < goal) begin
            take_now = random_take ? logic'($urandom_range(0, 1)) : 1'b1;
            drive_cycle(take_now, 1'b0, '0);
        end
    endtask

    task automatic branch_to(input logic [xlen-1:0] target);
        drive_cycle(1'b1, 1'b1, target);
    endtask

    // a few words behind the last accepted entry, still in the cache
    function automatic logic [xlen-1:0] target_behind();
        return last_pc - (xlen'($urandom_range(1, 15)) << 2);
    endfunction

    function automatic logic [xlen-1:0] target_far();
        return 32'h0000_6000 + (xlen'($urandom_range(0, 511)) << 2);
    endfunction

    initial begin
        void'($urandom(64));
        reset         = 1'b1;
        take          = 1'b0;
        take_branch   = 1'b0;
        branch_target = '0;
        accepted      = 0;
        last_pc       = reset_pc;
        repeat (reset_cycles) @(posedge clock);
        #2;
        reset = 1'b0;

        run_accepts(100, 1'b0);
        run_accepts(60, 1'b1);
        // back-pressure, queue fills and fetch stalls
        repeat (20) drive_cycle(1'b0, 1'b0, '0);
        run_accepts(20, 1'b0);

        for (int i = 0; i < 5; i++) begin
            branch_to((i % 2 == 0) ? target_behind() : target_far());
            run_accepts(20, i == 3);
        end

        // redirect while a line fill is still in flight
        branch_to(target_far());
        while (!mem_req) begin
            drive_cycle(1'b1, 1'b0, '0);
        end
        branch_to(target_far());
        run_accepts(30, 1'b0);

        repeat (4) drive_cycle(1'b0, 1'b0, '0);
        if (i_dut.i_checker.fail_count == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            $display("TEST FAILED");
            $fatal(1, "checker reported %0d failures", i_dut.i_checker.fail_count);
        end
    end

    // stop at the first failed assertion
    initial begin
        wait (i_dut.i_checker.fail_count != 0);
        $display("TEST FAILED");
        $fatal(1, "an assertion in the checker failed");
    end

    initial begin
        #(watchdog_time);
        $display("TEST FAILED");
        $fatal(1, "run timed out after %0d time units with %0d accepted", watchdog_time,
               accepted);
    end

endmodule

// File: compile.f
hdl/fetch_pkg.sv
hdl/icache.sv
hdl/prefetch_queue.sv
hdl/fetch_top.sv
tests/tb_clock.sv
tests/tb_memory.sv
tests/fetch_checker.sv
tests/tb_fetch.sv

// File: Bender.yml
package:
  name: fetch_front_end

sources:
  - hdl/fetch_pkg.sv
  - hdl/icache.sv
  - hdl/prefetch_queue.sv
  - hdl/fetch_top.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/tb_memory.sv
      - tests/fetch_checker.sv
      - tests/tb_fetch.sv
